// ==== design/data_ram.sv ====
// on-chip data RAM, 64-bit words, byte-masked write at the clock and async read
`timescale 1ns/1ps

module data_ram (
    input  logic     clk,
    dmem_if.ram_mp   dmem
);

    localparam int NBYTES = $bits(mem_stage_pkg::wmask_t); // lanes per word

    // storage, contents undefined until written
    mem_stage_pkg::xlen_t mem [mem_stage_pkg::DMEM_WORDS];

    // ************************************************************
    // write port
    // ************************************************************
    always_ff @(posedge clk) begin
        if (dmem.wen) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (dmem.wmask[b]) begin
                    mem[dmem.widx][8*b +: 8] <= dmem.wdata[8*b +: 8]; // masked lanes only
                end
            end
        end
    end

    // read port
    // combinational, so a load sees the last edge's store
    assign dmem.rdata = mem[dmem.ridx];

endmodule

// ==== design/dmem_if.sv ====
// bundle between the store/load logic and the data RAM, one modport per side
`timescale 1ns/1ps

interface dmem_if;

    // write side, from the store unit
    logic [mem_stage_pkg::DMEM_IDX_BITS-1:0] widx;  // word index
    logic                                    wen;   // one-cycle write strobe
    mem_stage_pkg::wmask_t                   wmask; // byte lanes to update
    mem_stage_pkg::xlen_t                    wdata; // lane-aligned store word

    // read side, async
    logic [mem_stage_pkg::DMEM_IDX_BITS-1:0] ridx;
    mem_stage_pkg::xlen_t                    rdata;

    modport store_mp (
        output widx, wen, wmask, wdata
    );

    modport load_mp (
        output ridx,
        input  rdata
    );

    modport ram_mp (
        input  widx, wen, wmask, wdata, ridx,
        output rdata
    );

endinterface

// ==== design/load_unit.sv ====
// load path: async RAM read at the address, byte lane pick and sign or zero extension
`timescale 1ns/1ps

module load_unit (
    input  mem_stage_pkg::mem_op_e q_op,
    input  mem_stage_pkg::xlen_t   q_alu,     // effective address
    dmem_if.load_mp                dmem,
    output mem_stage_pkg::xlen_t   load_data  // extended value for the gpr
);

    localparam int W = mem_stage_pkg::XLEN;

    logic [mem_stage_pkg::BYTE_OFS_BITS-1:0] byte_ofs;
    mem_stage_pkg::xlen_t                    shifted; // addressed byte moved to bit 0

    // word select, upper address bits dropped
    assign dmem.ridx = q_alu[mem_stage_pkg::BYTE_OFS_BITS +: mem_stage_pkg::DMEM_IDX_BITS];

    assign byte_ofs = q_alu[mem_stage_pkg::BYTE_OFS_BITS-1:0];
    assign shifted  = dmem.rdata >> {byte_ofs, 3'b000};

    // ************************************************************
    // extension per width
    // ************************************************************
    always_comb begin
        case (q_op)
            mem_stage_pkg::op_lb:
                load_data = {{(W-8){shifted[7]}}, shifted[7:0]};
            mem_stage_pkg::op_lh:
                load_data = {{(W-16){shifted[15]}}, shifted[15:0]};
            mem_stage_pkg::op_lw:
                load_data = {{(W-32){shifted[31]}}, shifted[31:0]};
            mem_stage_pkg::op_ld:
                load_data = shifted;                  // full word, offset is 0
            mem_stage_pkg::op_lbu:
                load_data = {{(W-8){1'b0}}, shifted[7:0]};
            mem_stage_pkg::op_lhu:
                load_data = {{(W-16){1'b0}}, shifted[15:0]};
            mem_stage_pkg::op_lwu:
                load_data = {{(W-32){1'b0}}, shifted[31:0]};
            default:
                load_data = '0; // non-load, keep wb mux input quiet
        endcase
    end

endmodule

// ==== design/mem_stage_pkg.sv ====
// shared widths, types, op enum and data RAM sizing for the memory stage, used by scoped names
package mem_stage_pkg;

    // ************************************************************
    // widths and field positions
    // ************************************************************
    localparam int XLEN          = 64;  // data and address width
    localparam int BYTE_OFS_BITS = 3;   // byte select within a doubleword
    localparam int RD_LSB        = 7;   // inst[11:7]
    localparam int RS2_LSB       = 20;  // inst[24:20]

    // data RAM geometry
    localparam int DMEM_WORDS    = 256; // depth in 64-bit words
    localparam int DMEM_IDX_BITS = 8;   // word index, addr bits above the byte offset

    // ************************************************************
    // types
    // ************************************************************
    typedef logic [XLEN-1:0] xlen_t;    // data / address word
    typedef logic [31:0]     inst_t;    // raw instruction
    typedef logic [4:0]      reg_id_t;  // gpr number
    typedef logic [7:0]      wmask_t;   // one bit per byte lane

    // what the stage does with the item
    typedef enum logic [3:0] {
        op_none, // bubble or no mem / wb work
        op_alu,  // write alu result
        op_link, // jal / jalr, write pc + 4
        op_csr,  // csr read value arrives on src2
        op_lb,
        op_lh,
        op_lw,
        op_ld,
        op_lbu,
        op_lhu,
        op_lwu,
        op_sb,
        op_sh,
        op_sw,
        op_sd
    } mem_op_e;

endpackage

// ==== design/mem_stage_reg.sv ====
// EX/MEM pipeline register that loads on advance and holds every field during a stall
`timescale 1ns/1ps

module mem_stage_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   advance,  // wb side ready
    input  logic                   in_valid,
    input  mem_stage_pkg::xlen_t   in_pc,
    input  mem_stage_pkg::inst_t   in_inst,
    input  mem_stage_pkg::mem_op_e in_op,
    input  mem_stage_pkg::xlen_t   in_alu,
    input  mem_stage_pkg::xlen_t   in_src2,
    output logic                   q_valid,
    output mem_stage_pkg::xlen_t   q_pc,
    output mem_stage_pkg::inst_t   q_inst,
    output mem_stage_pkg::mem_op_e q_op,
    output mem_stage_pkg::xlen_t   q_alu,
    output mem_stage_pkg::xlen_t   q_src2
);

    // ************************************************************
    // control part cleared on reset
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            q_valid <= 1'b0;
            q_op    <= mem_stage_pkg::op_none;
        end else if (advance) begin
            q_valid <= in_valid; // bubbles pass in as given
            q_op    <= in_op;
        end
        // else hold while wb stalls
    end

    // payload part loads together with the control part
    always_ff @(posedge clk) begin
        if (advance) begin
            q_pc   <= in_pc;
            q_inst <= in_inst;
            q_alu  <= in_alu;  // result or effective address
            q_src2 <= in_src2; // store data / csr read value
        end
    end

endmodule

// ==== design/mem_stage_top.sv ====
// memory stage top: EX/MEM register, store and load paths, data RAM and writeback select
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                   clk,
    input  logic                   rst,
    // from EX
    input  logic                   ex_valid,
    output logic                   ex_ready,
    input  mem_stage_pkg::xlen_t   pc,
    input  mem_stage_pkg::inst_t   inst,
    input  mem_stage_pkg::mem_op_e op,
    input  mem_stage_pkg::xlen_t   alu_out,
    input  mem_stage_pkg::xlen_t   src2,
    // to WB
    output logic                   mem_valid,
    input  logic                   wb_ready,
    output mem_stage_pkg::xlen_t   mem_pc,
    output mem_stage_pkg::inst_t   mem_inst,
    // forwarding source, the reg write in WB
    input  logic                   wb_wen,
    input  mem_stage_pkg::reg_id_t wb_rd,
    input  mem_stage_pkg::xlen_t   wb_wdata,
    // gpr write request
    output logic                   reg_wr_wen,
    output mem_stage_pkg::reg_id_t reg_wr_id,
    output mem_stage_pkg::xlen_t   reg_wr_value
);

    logic                   advance; // register takes a new item
    logic                   leaving; // held item retires
    logic                   q_valid;
    mem_stage_pkg::xlen_t   q_pc;
    mem_stage_pkg::inst_t   q_inst;
    mem_stage_pkg::mem_op_e q_op;
    mem_stage_pkg::xlen_t   q_alu;
    mem_stage_pkg::xlen_t   q_src2;
    mem_stage_pkg::xlen_t   load_data;

    dmem_if dmem_i ();

    // ************************************************************
    // handshake, no stall source inside this stage
    // ************************************************************
    assign advance  = wb_ready;
    assign ex_ready = advance;
    assign leaving  = q_valid && wb_ready;

    mem_stage_reg reg_i (
        .clk(clk), .rst(rst), .advance(advance),
        .in_valid(ex_valid), .in_pc(pc), .in_inst(inst),
        .in_op(op), .in_alu(alu_out), .in_src2(src2),
        .q_valid(q_valid), .q_pc(q_pc), .q_inst(q_inst),
        .q_op(q_op), .q_alu(q_alu), .q_src2(q_src2)
    );

    store_unit store_i (
        .q_valid(q_valid), .q_op(q_op), .q_inst(q_inst),
        .q_alu(q_alu), .q_src2(q_src2), .leaving(leaving),
        .wb_wen(wb_wen), .wb_rd(wb_rd), .wb_wdata(wb_wdata),
        .dmem(dmem_i.store_mp)
    );

    load_unit load_i (
        .q_op(q_op), .q_alu(q_alu), .dmem(dmem_i.load_mp), .load_data(load_data)
    );

    data_ram ram_i (
        .clk(clk), .dmem(dmem_i.ram_mp)
    );

    wb_select wbsel_i (
        .q_valid(q_valid), .q_op(q_op), .q_inst(q_inst), .q_pc(q_pc),
        .q_alu(q_alu), .q_src2(q_src2), .load_data(load_data),
        .reg_wr_wen(reg_wr_wen), .reg_wr_id(reg_wr_id), .reg_wr_value(reg_wr_value)
    );

    // registered item straight to WB
    assign mem_valid = q_valid;
    assign mem_pc    = q_pc;
    assign mem_inst  = q_inst;

endmodule

// ==== design/store_unit.sv ====
// store path: rs2 forwarding from writeback, then byte lane alignment and mask for the RAM
`timescale 1ns/1ps

module store_unit (
    input  logic                   q_valid,
    input  mem_stage_pkg::mem_op_e q_op,
    input  mem_stage_pkg::inst_t   q_inst,
    input  mem_stage_pkg::xlen_t   q_alu,    // effective address
    input  mem_stage_pkg::xlen_t   q_src2,
    input  logic                   leaving,  // item retires this edge
    input  logic                   wb_wen,
    input  mem_stage_pkg::reg_id_t wb_rd,
    input  mem_stage_pkg::xlen_t   wb_wdata,
    dmem_if.store_mp               dmem
);

    logic                                    is_store;
    logic                                    fwd_hit;
    mem_stage_pkg::reg_id_t                  rs2;
    mem_stage_pkg::xlen_t                    st_src;    // data after forwarding
    mem_stage_pkg::xlen_t                    lane;      // sized data at byte 0
    mem_stage_pkg::wmask_t                   size_mask; // mask at byte 0
    logic [mem_stage_pkg::BYTE_OFS_BITS-1:0] byte_ofs;

    assign is_store = (q_op == mem_stage_pkg::op_sb) || (q_op == mem_stage_pkg::op_sh) ||
                      (q_op == mem_stage_pkg::op_sw) || (q_op == mem_stage_pkg::op_sd);

    // ************************************************************
    // forwarding from wb
    // ************************************************************
    assign rs2     = q_inst[mem_stage_pkg::RS2_LSB +: 5];
    assign fwd_hit = is_store && wb_wen && (wb_rd == rs2) && (rs2 != '0); // x0 never forwards
    assign st_src  = fwd_hit ? wb_wdata : q_src2;

    // ************************************************************
    // size select, then shift to the byte offset
    // ************************************************************
    always_comb begin
        lane      = '0;
        size_mask = '0;
        case (q_op)
            mem_stage_pkg::op_sb: begin
                lane      = mem_stage_pkg::xlen_t'(st_src[7:0]);
                size_mask = 8'h01;
            end
            mem_stage_pkg::op_sh: begin
                lane      = mem_stage_pkg::xlen_t'(st_src[15:0]);
                size_mask = 8'h03;
            end
            mem_stage_pkg::op_sw: begin
                lane      = mem_stage_pkg::xlen_t'(st_src[31:0]);
                size_mask = 8'h0f;
            end
            mem_stage_pkg::op_sd: begin
                lane      = st_src;
                size_mask = 8'hff;
            end
            default: ; // not a store, nothing enabled
        endcase
    end

    assign byte_ofs   = q_alu[mem_stage_pkg::BYTE_OFS_BITS-1:0]; // aligned by contract
    assign dmem.widx  = q_alu[mem_stage_pkg::BYTE_OFS_BITS +: mem_stage_pkg::DMEM_IDX_BITS];
    assign dmem.wdata = lane << {byte_ofs, 3'b000};  // bytes to bits
    assign dmem.wmask = size_mask << byte_ofs;
    assign dmem.wen   = q_valid && is_store && leaving; // once per store, even if stalled

endmodule

// ==== design/wb_select.sv ====
// register writeback select: enable, rd and value from alu, pc + 4, csr src2 or load data
`timescale 1ns/1ps

module wb_select (
    input  logic                   q_valid,
    input  mem_stage_pkg::mem_op_e q_op,
    input  mem_stage_pkg::inst_t   q_inst,
    input  mem_stage_pkg::xlen_t   q_pc,
    input  mem_stage_pkg::xlen_t   q_alu,
    input  mem_stage_pkg::xlen_t   q_src2,
    input  mem_stage_pkg::xlen_t   load_data,
    output logic                   reg_wr_wen,
    output mem_stage_pkg::reg_id_t reg_wr_id,
    output mem_stage_pkg::xlen_t   reg_wr_value
);

    logic                 writes; // op class writes a gpr
    mem_stage_pkg::xlen_t value;

    always_comb begin
        writes = 1'b1;
        case (q_op)
            mem_stage_pkg::op_alu:  value = q_alu;
            mem_stage_pkg::op_link: value = q_pc + mem_stage_pkg::xlen_t'(4); // return addr
            mem_stage_pkg::op_csr:  value = q_src2;                          // old csr value
            mem_stage_pkg::op_lb, mem_stage_pkg::op_lh, mem_stage_pkg::op_lw,
            mem_stage_pkg::op_ld, mem_stage_pkg::op_lbu, mem_stage_pkg::op_lhu,
            mem_stage_pkg::op_lwu:  value = load_data;
            default: begin
                writes = 1'b0;   // stores and op_none
                value  = '0;
            end
        endcase
    end

    // ************************************************************
    // outputs zeroed for bubbles and non-writers
    // ************************************************************
    assign reg_wr_wen   = q_valid && writes;
    assign reg_wr_id    = reg_wr_wen ? q_inst[mem_stage_pkg::RD_LSB +: 5] : '0;
    assign reg_wr_value = reg_wr_wen ? value : '0;

endmodule

// ==== mem_stage.f ====
design/mem_stage_pkg.sv
design/dmem_if.sv
design/mem_stage_reg.sv
design/store_unit.sv
design/load_unit.sv
design/data_ram.sv
design/wb_select.sv
design/mem_stage_top.sv
testbench/mem_stage_checker.sv
testbench/tb_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the mem_stage testbench with Verilator, run it, fail on any bad status or failing log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mem_stage -f mem_stage.f \
    -Mdir obj_dir -o sim_mem_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mem_stage > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== testbench/mem_stage_checker.sv ====
// testbench checker: tracks the EX/MEM item and a byte model of the RAM, compares DUT outputs
`timescale 1ns/1ps

module mem_stage_checker (
    input  logic                   clk, rst,
    input  logic                   ex_valid, ex_ready, wb_ready, wb_wen,
    input  mem_stage_pkg::xlen_t   pc, alu_out, src2, wb_wdata,
    input  mem_stage_pkg::inst_t   inst,
    input  mem_stage_pkg::mem_op_e op,
    input  mem_stage_pkg::reg_id_t wb_rd,
    input  logic                   mem_valid, reg_wr_wen,   // DUT outputs
    input  mem_stage_pkg::xlen_t   mem_pc, reg_wr_value,
    input  mem_stage_pkg::inst_t   mem_inst,
    input  mem_stage_pkg::reg_id_t reg_wr_id,
    output int                     error_count,
    output int                     check_count
);

    localparam int ABITS = mem_stage_pkg::DMEM_IDX_BITS + mem_stage_pkg::BYTE_OFS_BITS;

    logic [7:0] mem_bytes [2**ABITS]; // byte model, word index above the byte offset
    int   errors  = 0;
    int   checks  = 0;
    logic started = 1'b0;             // first reset edge seen

    // ************************************************************
    // tracked copy of the registered item
    // ************************************************************
    logic                   t_valid = 1'b0;
    mem_stage_pkg::mem_op_e t_op    = mem_stage_pkg::op_none;
    mem_stage_pkg::xlen_t   t_pc, t_alu, t_src2;
    mem_stage_pkg::inst_t   t_inst;
    logic                   exp_wen;

    assign error_count = errors;
    assign check_count = checks;

    function automatic int access_bytes(input mem_stage_pkg::mem_op_e o);
        case (o)
            mem_stage_pkg::op_lh, mem_stage_pkg::op_lhu, mem_stage_pkg::op_sh: return 2;
            mem_stage_pkg::op_lw, mem_stage_pkg::op_lwu, mem_stage_pkg::op_sw: return 4;
            mem_stage_pkg::op_ld, mem_stage_pkg::op_sd:                        return 8;
            default:                                                           return 1;
        endcase
    endfunction

    function automatic logic is_store(input mem_stage_pkg::mem_op_e o);
        return o inside {mem_stage_pkg::op_sb, mem_stage_pkg::op_sh,
                         mem_stage_pkg::op_sw, mem_stage_pkg::op_sd};
    endfunction

    function automatic logic is_load(input mem_stage_pkg::mem_op_e o);
        return o inside {mem_stage_pkg::op_lb, mem_stage_pkg::op_lh, mem_stage_pkg::op_lw,
                         mem_stage_pkg::op_ld, mem_stage_pkg::op_lbu, mem_stage_pkg::op_lhu,
                         mem_stage_pkg::op_lwu};
    endfunction

    function automatic string test_name();
        if (!t_valid) return "bubble";
        if (is_load(t_op)) return "load";
        if (is_store(t_op)) return "store";
        if (t_op == mem_stage_pkg::op_none) return "no_op";
        return "wb_select";
    endfunction

    // value the gpr should get, from the ISA rules and the byte model
    function automatic mem_stage_pkg::xlen_t expected_value();
        mem_stage_pkg::xlen_t raw;
        logic [ABITS-1:0]     base;
        logic                 neg;
        int                   n;
        case (t_op)
            mem_stage_pkg::op_alu:  return t_alu;
            mem_stage_pkg::op_link: return t_pc + 64'd4;
            mem_stage_pkg::op_csr:  return t_src2;
            default: ;
        endcase
        if (!is_load(t_op)) return '0;
        raw  = '0;
        base = t_alu[ABITS-1:0];
        n    = access_bytes(t_op);
        for (int k = 0; k < 8; k++) begin
            if (k < n) raw[8*k +: 8] = mem_bytes[base + k[ABITS-1:0]];
        end
        neg = (t_op == mem_stage_pkg::op_lb && raw[7]) ||
              (t_op == mem_stage_pkg::op_lh && raw[15]) ||
              (t_op == mem_stage_pkg::op_lw && raw[31]);  // signed loads only
        for (int k = 0; k < 8; k++) begin
            if (k >= n && neg) raw[8*k +: 8] = 8'hff;
        end
        return raw;
    endfunction

    // store leaving now: forwarded or src2 data into the low bytes of the access
    task automatic apply_store();
        mem_stage_pkg::xlen_t   data;
        mem_stage_pkg::reg_id_t rs2;
        logic [ABITS-1:0]       base;
        int                     n;
        rs2  = t_inst[mem_stage_pkg::RS2_LSB +: 5];
        data = (wb_wen && wb_rd == rs2 && rs2 != 5'd0) ? wb_wdata : t_src2;
        base = t_alu[ABITS-1:0];
        n    = access_bytes(t_op);
        for (int k = 0; k < 8; k++) begin
            if (k < n) mem_bytes[base + k[ABITS-1:0]] = data[8*k +: 8];
        end
    endtask

    task automatic compare(input string name, input string field,
                           input mem_stage_pkg::xlen_t exp, input mem_stage_pkg::xlen_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h at %0t", name, field, exp, act, $time);
        end
    endtask

    // ************************************************************
    // edge: RAM write on leave, then register update
    // ************************************************************
    always @(posedge clk) begin
        if (t_valid && wb_ready && is_store(t_op)) apply_store(); // once, on leaving
        if (rst) begin
            started = 1'b1;
            t_valid = 1'b0;
            t_op    = mem_stage_pkg::op_none;
        end else if (wb_ready) begin
            t_valid = ex_valid;
            t_pc    = pc;
            t_inst  = inst;
            t_op    = op;
            t_alu   = alu_out;
            t_src2  = src2;
        end
    end

    // mid-cycle, all outputs settled
    always @(negedge clk) begin
        if (started) begin
            compare("handshake", "ex_ready", 64'(wb_ready), 64'(ex_ready));
            compare("pass_through", "mem_valid", 64'(t_valid), 64'(mem_valid));
            if (t_valid) begin
                compare("pass_through", "mem_pc", t_pc, mem_pc);
                compare("pass_through", "mem_inst", 64'(t_inst), 64'(mem_inst));
            end
            exp_wen = t_valid && (is_load(t_op) || t_op == mem_stage_pkg::op_alu ||
                      t_op == mem_stage_pkg::op_link || t_op == mem_stage_pkg::op_csr);
            compare(test_name(), "reg_wr_wen", 64'(exp_wen), 64'(reg_wr_wen));
            compare(test_name(), "reg_wr_id",
                    exp_wen ? 64'(t_inst[mem_stage_pkg::RD_LSB +: 5]) : 64'd0, 64'(reg_wr_id));
            compare(test_name(), "reg_wr_value", exp_wen ? expected_value() : 64'd0,
                    reg_wr_value);
        end
    end

endmodule

// ==== testbench/tb_mem_stage.sv ====
// simulation top driving xorshift EX items and WB back-pressure into the stage, with timeout
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int FILL_ITEMS     = mem_stage_pkg::DMEM_WORDS; // one sd per RAM word
    localparam int RANDOM_ITEMS   = 600;
    localparam int MARGIN_CYCLES  = 40;                         // reset and drain
    localparam int TIMEOUT_CYCLES = (FILL_ITEMS + RANDOM_ITEMS) * 4 + MARGIN_CYCLES;

    logic                   clk, rst;
    logic                   ex_valid, ex_ready, wb_ready, wb_wen;
    logic                   mem_valid, reg_wr_wen;
    mem_stage_pkg::xlen_t   pc, alu_out, src2, wb_wdata, mem_pc, reg_wr_value;
    mem_stage_pkg::inst_t   inst, mem_inst;
    mem_stage_pkg::mem_op_e op;
    mem_stage_pkg::reg_id_t wb_rd, reg_wr_id;
    int                     error_count, check_count;
    int                     cycles    = 0;
    logic [63:0]            rng_state = 64'd20; // seed
    logic [7:0]             last_idx  = 8'd0;   // reused now and then for store then load

    mem_stage_top dut_i (.*);

    mem_stage_checker checker_i (.*);

    always #20 clk = ~clk;

    function automatic logic [63:0] xorshift64(input logic [63:0] x);
        logic [63:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 7);
        return y ^ (y << 17);
    endfunction

    task automatic draw(output logic [63:0] r);
        rng_state = xorshift64(rng_state);
        r = rng_state;
    endtask

    function automatic int size_in_bytes(input mem_stage_pkg::mem_op_e o);
        case (o)
            mem_stage_pkg::op_lh, mem_stage_pkg::op_lhu, mem_stage_pkg::op_sh: return 2;
            mem_stage_pkg::op_lw, mem_stage_pkg::op_lwu, mem_stage_pkg::op_sw: return 4;
            mem_stage_pkg::op_ld, mem_stage_pkg::op_sd:                        return 8;
            default:                                                           return 1;
        endcase
    endfunction

    // new WB side values each cycle with small register numbers so forwarding hits often
    task automatic drive_wb_side();
        logic [63:0] r;
        draw(r);
        wb_ready = (r[1:0] != 2'b00); // stall one cycle in four
        wb_wen   = r[2];
        wb_rd    = {3'b000, r[4:3]};
        draw(r);
        wb_wdata = r;
    endtask

    // hold the item until an edge with ex_ready high takes it
    task automatic send_item(input logic v, input mem_stage_pkg::xlen_t p,
                             input mem_stage_pkg::inst_t i, input mem_stage_pkg::mem_op_e o,
                             input mem_stage_pkg::xlen_t a, input mem_stage_pkg::xlen_t s);
        logic accepted;
        ex_valid = v;
        pc       = p;
        inst     = i;
        op       = o;
        alu_out  = a;
        src2     = s;
        accepted = 1'b0;
        while (!accepted) begin
            drive_wb_side();
            @(negedge clk);
            accepted = ex_ready;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, errors %0d", check_count, error_count);
    endtask

    // ************************************************************
    // stimulus
    // ************************************************************
    initial begin
        logic [63:0]            r1, r2, r3, r4;
        logic [7:0]             idx;
        logic [2:0]             ofs;
        mem_stage_pkg::mem_op_e o;
        mem_stage_pkg::inst_t   i;
        clk      = 1'b0;
        rst      = 1'b1;
        ex_valid = 1'b0;
        pc       = '0;
        inst     = '0;
        op       = mem_stage_pkg::op_none;
        alu_out  = '0;
        src2     = '0;
        wb_ready = 1'b1;
        wb_wen   = 1'b0;
        wb_rd    = '0;
        wb_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // fill every word so the model knows the whole RAM
        for (int w = 0; w < FILL_ITEMS; w++) begin
            draw(r1);
            draw(r2);
            i = r1[31:0];
            i[mem_stage_pkg::RS2_LSB +: 5] = {3'b000, r1[33:32]};
            send_item(1'b1, {r2[63:2], 2'b00}, i, mem_stage_pkg::op_sd,
                      {r1[63:11], w[7:0], 3'b000}, r2);
        end

        // random mix with a bubble about one item in sixteen
        for (int n = 0; n < RANDOM_ITEMS; n++) begin
            draw(r1);
            draw(r2);
            draw(r3);
            draw(r4);
            o        = mem_stage_pkg::mem_op_e'(r1[7:4] % 4'd15);
            idx      = (r1[9:8] == 2'b00) ? last_idx : r1[17:10];
            last_idx = idx;
            ofs      = r1[20:18] & ~3'(size_in_bytes(o) - 1); // natural alignment
            i        = r1[63:32];
            i[mem_stage_pkg::RS2_LSB +: 5] = {3'b000, r1[22:21]};
            send_item(r1[3:0] != 4'd0, {r3[63:2], 2'b00}, i, o,
                      (o inside {mem_stage_pkg::op_none, mem_stage_pkg::op_alu,
                                 mem_stage_pkg::op_link, mem_stage_pkg::op_csr}) ?
                      r2 : {r2[63:11], idx, ofs}, r4);
        end

        // drain so the last item leaves
        ex_valid = 1'b0;
        op       = mem_stage_pkg::op_none;
        wb_ready = 1'b1;
        wb_wen   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        #1; // after the last compare of the checker

        print_counts();
        if (error_count == 0 && check_count > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run limit from the item count
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles with items still not accepted", cycles);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule
